//--- sim.f
source/tlb_pkg.sv
source/xlate_pkg.sv
source/tlb_array.sv
source/addr_translator.sv
source/xlate_arbiter.sv
source/mmu_top.sv
tb/mmu_assert.sv
tb/mmu_tb.sv

//--- Makefile
TOP = mmu_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sim.f $(wildcard source/*.sv tb/*.sv)
	verilator --binary --timing --assert -f sim.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || (echo "simulation did not complete"; exit 1)

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- tb/mmu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mmu_tb;
    import xlate_pkg::*;
    import tlb_pkg::*;

    localparam int clk_period = 100;
    // upper bound on the translations issued by all tests
    localparam int num_reqs = 32;

    logic      clk = 1'b0;
    logic      rst_n = 1'b0;
    logic      if_req = 1'b0;
    vaddr_t    if_va = '0;
    logic      if_done;
    paddr_t    if_pa;
    xlate_ex_t if_ex;
    logic      ls_req = 1'b0;
    vaddr_t    ls_va = '0;
    logic      ls_store = 1'b0;
    logic      ls_done;
    paddr_t    ls_pa;
    xlate_ex_t ls_ex;
    csr_word_t csr_crmd = '0;
    csr_word_t csr_asid = '0;
    csr_word_t csr_dmw0 = '0;
    csr_word_t csr_dmw1 = '0;
    logic      tlb_we = 1'b0;
    tlb_idx_t  tlb_w_index = '0;
    logic      tlb_w_e = 1'b0;
    vppn_t     tlb_w_vppn = '0;
    ps_t       tlb_w_ps = '0;
    asid_t     tlb_w_asid = '0;
    logic      tlb_w_g = 1'b0;
    ppn_t      tlb_w_ppn0 = '0;
    plv_t      tlb_w_plv0 = '0;
    logic      tlb_w_d0 = 1'b0;
    logic      tlb_w_v0 = 1'b0;
    ppn_t      tlb_w_ppn1 = '0;
    plv_t      tlb_w_plv1 = '0;
    logic      tlb_w_d1 = 1'b0;
    logic      tlb_w_v1 = 1'b0;

    // shadow copy of the TLB entries written so far
    logic  sh_e    [tlb_num] = '{default: 1'b0};
    logic  sh_g    [tlb_num];
    vppn_t sh_vppn [tlb_num];
    ps_t   sh_ps   [tlb_num];
    asid_t sh_asid [tlb_num];
    ppn_t  sh_ppn  [tlb_num][2];
    plv_t  sh_plv  [tlb_num][2];
    logic  sh_d    [tlb_num][2];
    logic  sh_v    [tlb_num][2];

    int seed = 64255;

    mmu_top dut0 (.*);

    bind xlate_arbiter mmu_assert chk0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .if_req  (if_req),
        .ls_req  (ls_req),
        .if_pend (if_pend),
        .ls_pend (ls_pend),
        .if_done (if_done),
        .ls_done (ls_done)
    );

    always #(clk_period / 2) clk = ~clk;

    // expected translation from the CSR levels and the shadow TLB
    function automatic void ref_xlate(input vaddr_t va, input access_t op,
            output paddr_t pa, output xlate_ex_t ex);
        plv_t plv;
        int   hit;
        logic huge;
        logic odd;
        plv = csr_crmd[crmd_plv_lo +: 2];
        ex  = '0;
        pa  = va;
        hit = -1;
        if (csr_crmd[crmd_da] && !csr_crmd[crmd_pg]) begin
            return;
        end
        if (csr_dmw0[plv] && csr_dmw0[31:29] == va[31:29]) begin
            pa = {csr_dmw0[27:25], va[28:0]};
            return;
        end
        if (csr_dmw1[plv] && csr_dmw1[31:29] == va[31:29]) begin
            pa = {csr_dmw1[27:25], va[28:0]};
            return;
        end
        for (int i = tlb_num - 1; i >= 0; i--) begin
            huge = (sh_ps[i] == ps_4m);
            if (sh_e[i] && (sh_g[i] || sh_asid[i] == csr_asid[9:0])
                    && (huge ? sh_vppn[i][18:10] == va[31:23] : sh_vppn[i] == va[31:13])) begin
                hit = i;
            end
        end
        if (hit < 0) begin
            ex[ex_tlbr] = 1'b1;
            return;
        end
        huge = (sh_ps[hit] == ps_4m);
        odd  = huge ? va[22] : va[12];
        pa   = huge ? {sh_ppn[hit][odd][19:10], va[21:0]} : {sh_ppn[hit][odd], va[11:0]};
        ex[ex_pif] = (op == acc_fetch) && !sh_v[hit][odd];
        ex[ex_pil] = (op == acc_load) && !sh_v[hit][odd];
        ex[ex_pis] = (op == acc_store) && !sh_v[hit][odd];
        ex[ex_ppi] = plv > sh_plv[hit][odd];
        ex[ex_pme] = (op == acc_store) && !sh_d[hit][odd];
    endfunction

    task automatic check_pa(input paddr_t got, input paddr_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s pa %h, expected %h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic check_ex(input xlate_ex_t got, input xlate_ex_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s ex %b, expected %b", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic check_lat(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("Fail at %0t: %s done after %0d cycles, expected %0d",
                $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic write_entry(input tlb_idx_t idx, input vppn_t vppn, input ps_t ps,
            input asid_t asid, input logic g, input ppn_t ppn0, input plv_t plv0,
            input logic d0, input logic v0, input ppn_t ppn1, input plv_t plv1,
            input logic d1, input logic v1);
        @(negedge clk);
        tlb_we      = 1'b1;
        tlb_w_index = idx;
        tlb_w_e     = 1'b1;
        tlb_w_vppn  = vppn;
        tlb_w_ps    = ps;
        tlb_w_asid  = asid;
        tlb_w_g     = g;
        tlb_w_ppn0  = ppn0;
        tlb_w_plv0  = plv0;
        tlb_w_d0    = d0;
        tlb_w_v0    = v0;
        tlb_w_ppn1  = ppn1;
        tlb_w_plv1  = plv1;
        tlb_w_d1    = d1;
        tlb_w_v1    = v1;
        sh_e[idx]    = 1'b1;
        sh_vppn[idx] = vppn;
        sh_ps[idx]   = ps;
        sh_asid[idx] = asid;
        sh_g[idx]    = g;
        sh_ppn[idx]  = '{ppn0, ppn1};
        sh_plv[idx]  = '{plv0, plv1};
        sh_d[idx]    = '{d0, d1};
        sh_v[idx]    = '{v0, v1};
        @(negedge clk);
        tlb_we = 1'b0;
    endtask

    // one strobe cycle, then count cycles until each done pulse
    task automatic send_requests(input logic use_if, input logic use_ls, input vaddr_t iva,
            input vaddr_t lva, input logic store, output int if_lat, output int ls_lat);
        int n;
        n = 0;
        if_lat = 0;
        ls_lat = 0;
        @(negedge clk);
        if_req   = use_if;
        if_va    = iva;
        ls_req   = use_ls;
        ls_va    = lva;
        ls_store = store;
        while ((use_if && if_lat == 0) || (use_ls && ls_lat == 0)) begin
            if (n == 8) begin
                $display("No done pulse within %0d cycles of the request at %0t", n, $time);
                $display("Done: errors found");
                $fatal(1);
            end
            @(negedge clk);
            if_req = 1'b0;
            ls_req = 1'b0;
            n++;
            if (if_done) begin
                if_lat = n;
            end
            if (ls_done) begin
                ls_lat = n;
            end
        end
    endtask

    task automatic check_result(input logic on_ls, input vaddr_t va, input access_t op,
            input int lat, input int exp_lat, input string what);
        paddr_t    exp_pa;
        xlate_ex_t exp_ex;
        ref_xlate(va, op, exp_pa, exp_ex);
        check_lat(lat, exp_lat, what);
        check_ex(on_ls ? ls_ex : if_ex, exp_ex, what);
        // address is undefined on a TLB miss
        if (!exp_ex[ex_tlbr]) begin
            check_pa(on_ls ? ls_pa : if_pa, exp_pa, what);
        end
    endtask

    task automatic do_fetch(input vaddr_t va, input string what);
        int il;
        int ll;
        send_requests(1'b1, 1'b0, va, '0, 1'b0, il, ll);
        check_result(1'b0, va, acc_fetch, il, 2, what);
    endtask

    task automatic do_data(input vaddr_t va, input logic store, input string what);
        int il;
        int ll;
        send_requests(1'b0, 1'b1, '0, va, store, il, ll);
        check_result(1'b1, va, store ? acc_store : acc_load, ll, 2, what);
    endtask

    task automatic do_both(input vaddr_t iva, input vaddr_t lva, input logic store,
            input logic fetch_first, input string what);
        int il;
        int ll;
        send_requests(1'b1, 1'b1, iva, lva, store, il, ll);
        check_result(1'b0, iva, acc_fetch, il, fetch_first ? 2 : 3, what);
        check_result(1'b1, lva, store ? acc_store : acc_load, ll, fetch_first ? 3 : 2, what);
    endtask

    task automatic test_direct();
        vaddr_t va;
        csr_crmd = 32'h0000_0008;
        for (int i = 0; i < 4; i++) begin
            va = $random(seed);
            do_fetch(va, "direct fetch");
            va = $random(seed);
            do_data(va, 1'b0, "direct load");
            va = $random(seed);
            do_data(va, 1'b1, "direct store");
        end
    endtask

    task automatic test_windows();
        vaddr_t r;
        // both windows cover segment 4 at plv 0
        csr_crmd = 32'h0000_0010;
        csr_dmw0 = 32'h8200_0001;
        csr_dmw1 = 32'h8400_0001;
        r = $random(seed);
        do_fetch({3'b100, r[28:0]}, "window 0 over window 1");
        r = $random(seed);
        do_data({3'b100, r[28:0]}, 1'b0, "window 0 load");
        csr_dmw1 = 32'hA600_0001;
        r = $random(seed);
        do_data({3'b101, r[28:0]}, 1'b1, "window 1 store");
        // plv 3 not enabled in either window
        csr_crmd = 32'h0000_0013;
        r = $random(seed);
        do_fetch({3'b100, r[28:0]}, "window plv fall through");
        csr_dmw0 = '0;
        csr_dmw1 = '0;
    endtask

    task automatic test_tlb_4k();
        vaddr_t r;
        csr_crmd = 32'h0000_0010;
        csr_asid = 32'h0000_0005;
        write_entry(4'd0, 19'h12345, ps_4k, 10'd5, 1'b0,
            20'hAAAAA, 2'd3, 1'b1, 1'b1, 20'h55555, 2'd3, 1'b1, 1'b1);
        write_entry(4'd1, 19'h00777, ps_4k, 10'd9, 1'b1,
            20'h01234, 2'd3, 1'b1, 1'b1, 20'h04321, 2'd3, 1'b1, 1'b1);
        r = $random(seed);
        do_fetch({19'h12345, 1'b0, r[11:0]}, "4k even page");
        r = $random(seed);
        do_data({19'h12345, 1'b1, r[11:0]}, 1'b0, "4k odd page");
        csr_asid = 32'h0000_0006;
        r = $random(seed);
        do_data({19'h00777, 1'b1, r[11:0]}, 1'b1, "4k global entry");
        r = $random(seed);
        do_fetch({19'h12345, 1'b0, r[11:0]}, "4k asid miss");
    endtask

    task automatic test_tlb_4m();
        vaddr_t r;
        csr_crmd = 32'h0000_0010;
        write_entry(4'd2, {9'h1F0, 10'h000}, ps_4m, 10'd3, 1'b1,
            20'h3FC00, 2'd3, 1'b1, 1'b1, 20'h00400, 2'd3, 1'b1, 1'b1);
        // bit 12 opposite to bit 22 so only bit 22 can pick the page
        r = $random(seed);
        do_fetch({9'h1F0, 1'b0, r[21:13], 1'b1, r[11:0]}, "4m even page");
        r = $random(seed);
        do_data({9'h1F0, 1'b1, r[21:13], 1'b0, r[11:0]}, 1'b0, "4m odd page");
    endtask

    task automatic test_flags();
        vaddr_t r;
        csr_crmd = 32'h0000_0010;
        // even page invalid, odd page clean and plv 0
        write_entry(4'd3, 19'h03000, ps_4k, 10'd0, 1'b1,
            20'h11111, 2'd3, 1'b1, 1'b0, 20'h22222, 2'd0, 1'b0, 1'b1);
        r = $random(seed);
        do_fetch({19'h03000, 1'b0, r[11:0]}, "fetch invalid page");
        do_data({19'h03000, 1'b0, r[11:0]}, 1'b0, "load invalid page");
        do_data({19'h03000, 1'b0, r[11:0]}, 1'b1, "store invalid page");
        do_data({19'h03000, 1'b1, r[11:0]}, 1'b1, "store clean page");
        csr_crmd = 32'h0000_0013;
        do_data({19'h03000, 1'b1, r[11:0]}, 1'b0, "privilege above page");
    endtask

    task automatic test_contention();
        vaddr_t r;
        vaddr_t s;
        csr_crmd = 32'h0000_0010;
        csr_asid = 32'h0000_0005;
        r = $random(seed);
        s = $random(seed);
        do_both({19'h12345, 1'b0, r[11:0]}, {9'h1F0, 1'b0, s[21:0]}, 1'b0, 1'b1,
            "first contention");
        r = $random(seed);
        s = $random(seed);
        do_both({19'h00777, 1'b1, r[11:0]}, {19'h03000, 1'b1, s[11:0]}, 1'b1, 1'b0,
            "second contention");
    endtask

    initial begin
        #(num_reqs * 20 * clk_period);
        $display("Timeout: the tests hung and did not finish within %0d cycles", num_reqs * 20);
        $display("Done: errors found");
        $fatal(1);
    end

    initial begin
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_direct();
        test_windows();
        test_tlb_4k();
        test_tlb_4m();
        test_flags();
        test_contention();
        if (dut0.arb0.chk0.fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("%0d assertion failures were reported", dut0.arb0.chk0.fails);
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/mmu_assert.sv
`timescale 1ns/1ns
`default_nettype none

module mmu_assert (
    input wire clk,
    input wire rst_n,
    input wire if_req,
    input wire ls_req,
    input wire if_pend,
    input wire ls_pend,
    input wire if_done,
    input wire ls_done
);
    int fails = 0;

    // one grant per cycle, so one done per cycle
    single_done: assert property (@(posedge clk) disable iff (!rst_n)
        !(if_done && ls_done))
        else begin
            $error("both done pulses high in one cycle");
            fails++;
        end

    // a side waits for its done before the next strobe
    if_one_pending: assert property (@(posedge clk) disable iff (!rst_n)
        !(if_req && if_pend))
        else begin
            $error("fetch strobe while a fetch is pending");
            fails++;
        end

    ls_one_pending: assert property (@(posedge clk) disable iff (!rst_n)
        !(ls_req && ls_pend))
        else begin
            $error("data strobe while a data request is pending");
            fails++;
        end

    // done two cycles after the strobe, three when it lost the grant
    if_latency: assert property (@(posedge clk) disable iff (!rst_n)
        if_req |-> ##3 (if_done || $past(if_done)))
        else begin
            $error("fetch done missing within three cycles");
            fails++;
        end

    ls_latency: assert property (@(posedge clk) disable iff (!rst_n)
        ls_req |-> ##3 (ls_done || $past(ls_done)))
        else begin
            $error("data done missing within three cycles");
            fails++;
        end

endmodule

`default_nettype wire

//--- source/mmu_top.sv
`timescale 1ns/1ns
`default_nettype none

module mmu_top (
    input  wire                        clk,
    input  wire                        rst_n,
    // fetch side
    input  wire                        if_req,
    input  wire xlate_pkg::vaddr_t     if_va,
    output logic                       if_done,
    output xlate_pkg::paddr_t          if_pa,
    output xlate_pkg::xlate_ex_t       if_ex,
    // load/store side
    input  wire                        ls_req,
    input  wire xlate_pkg::vaddr_t     ls_va,
    input  wire                        ls_store,
    output logic                       ls_done,
    output xlate_pkg::paddr_t          ls_pa,
    output xlate_pkg::xlate_ex_t       ls_ex,
    // CSR levels
    input  wire xlate_pkg::csr_word_t  csr_crmd,
    input  wire xlate_pkg::csr_word_t  csr_asid,
    input  wire xlate_pkg::csr_word_t  csr_dmw0,
    input  wire xlate_pkg::csr_word_t  csr_dmw1,
    // TLB write port
    input  wire                        tlb_we,
    input  wire tlb_pkg::tlb_idx_t     tlb_w_index,
    input  wire                        tlb_w_e,
    input  wire tlb_pkg::vppn_t        tlb_w_vppn,
    input  wire tlb_pkg::ps_t          tlb_w_ps,
    input  wire tlb_pkg::asid_t        tlb_w_asid,
    input  wire                        tlb_w_g,
    input  wire tlb_pkg::ppn_t         tlb_w_ppn0,
    input  wire tlb_pkg::plv_t         tlb_w_plv0,
    input  wire                        tlb_w_d0,
    input  wire                        tlb_w_v0,
    input  wire tlb_pkg::ppn_t         tlb_w_ppn1,
    input  wire tlb_pkg::plv_t         tlb_w_plv1,
    input  wire                        tlb_w_d1,
    input  wire                        tlb_w_v1
);
    import xlate_pkg::*;
    import tlb_pkg::*;

    // arbiter to translator
    vaddr_t    grant_va;
    access_t   grant_op;
    paddr_t    xl_pa;
    xlate_ex_t xl_ex;

    // translator to TLB
    vppn_t     s_vppn;
    logic      s_va_bit12;
    logic      s_va_bit22;
    asid_t     s_asid;
    logic      s_found;
    ppn_t      s_ppn;
    ps_t       s_ps;
    plv_t      s_plv;
    logic      s_d;
    logic      s_v;

    xlate_arbiter arb0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_req   (if_req),
        .if_va    (if_va),
        .ls_req   (ls_req),
        .ls_va    (ls_va),
        .ls_store (ls_store),
        .xl_pa    (xl_pa),
        .xl_ex    (xl_ex),
        .grant_va (grant_va),
        .grant_op (grant_op),
        .if_done  (if_done),
        .if_pa    (if_pa),
        .if_ex    (if_ex),
        .ls_done  (ls_done),
        .ls_pa    (ls_pa),
        .ls_ex    (ls_ex)
    );

    addr_translator xlt0 (
        .grant_va   (grant_va),
        .grant_op   (grant_op),
        .csr_crmd   (csr_crmd),
        .csr_asid   (csr_asid),
        .csr_dmw0   (csr_dmw0),
        .csr_dmw1   (csr_dmw1),
        .s_vppn     (s_vppn),
        .s_va_bit12 (s_va_bit12),
        .s_va_bit22 (s_va_bit22),
        .s_asid     (s_asid),
        .s_found    (s_found),
        .s_ppn      (s_ppn),
        .s_ps       (s_ps),
        .s_plv      (s_plv),
        .s_d        (s_d),
        .s_v        (s_v),
        .xl_pa      (xl_pa),
        .xl_ex      (xl_ex)
    );

    tlb_array tlb0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .tlb_we      (tlb_we),
        .tlb_w_index (tlb_w_index),
        .tlb_w_e     (tlb_w_e),
        .tlb_w_vppn  (tlb_w_vppn),
        .tlb_w_ps    (tlb_w_ps),
        .tlb_w_asid  (tlb_w_asid),
        .tlb_w_g     (tlb_w_g),
        .tlb_w_ppn0  (tlb_w_ppn0),
        .tlb_w_plv0  (tlb_w_plv0),
        .tlb_w_d0    (tlb_w_d0),
        .tlb_w_v0    (tlb_w_v0),
        .tlb_w_ppn1  (tlb_w_ppn1),
        .tlb_w_plv1  (tlb_w_plv1),
        .tlb_w_d1    (tlb_w_d1),
        .tlb_w_v1    (tlb_w_v1),
        .s_vppn      (s_vppn),
        .s_va_bit12  (s_va_bit12),
        .s_va_bit22  (s_va_bit22),
        .s_asid      (s_asid),
        .s_found     (s_found),
        .s_ppn       (s_ppn),
        .s_ps        (s_ps),
        .s_plv       (s_plv),
        .s_d         (s_d),
        .s_v         (s_v)
    );

endmodule

`default_nettype wire

//--- source/xlate_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module xlate_arbiter (
    input  wire                        clk,
    input  wire                        rst_n,
    // fetch side
    input  wire                        if_req,
    input  wire xlate_pkg::vaddr_t     if_va,
    // load/store side
    input  wire                        ls_req,
    input  wire xlate_pkg::vaddr_t     ls_va,
    input  wire                        ls_store,
    // from the translator
    input  wire xlate_pkg::paddr_t     xl_pa,
    input  wire xlate_pkg::xlate_ex_t  xl_ex,
    // to the translator
    output xlate_pkg::vaddr_t          grant_va,
    output xlate_pkg::access_t         grant_op,
    // results
    output logic                       if_done,
    output xlate_pkg::paddr_t          if_pa,
    output xlate_pkg::xlate_ex_t       if_ex,
    output logic                       ls_done,
    output xlate_pkg::paddr_t          ls_pa,
    output xlate_pkg::xlate_ex_t       ls_ex
);
    import xlate_pkg::*;

    logic     if_pend;
    logic     ls_pend;
    vaddr_t   if_va_q;
    vaddr_t   ls_va_q;
    access_t  ls_op_q;
    req_src_t last_win;
    req_src_t winner;
    logic     grant_valid;
    logic     contended;
    logic     if_grant;
    logic     ls_grant;

    assign grant_valid = if_pend | ls_pend;
    assign contended   = if_pend & ls_pend;

    // the side that lost the last contest goes first
    always_comb begin
        if (contended) begin
            winner = (last_win == src_fetch) ? src_data : src_fetch;
        end else if (if_pend) begin
            winner = src_fetch;
        end else begin
            winner = src_data;
        end
    end

    assign if_grant = grant_valid & (winner == src_fetch);
    assign ls_grant = grant_valid & (winner == src_data);

    assign grant_va = (winner == src_fetch) ? if_va_q : ls_va_q;
    assign grant_op = (winner == src_fetch) ? acc_fetch : ls_op_q;

    // last_win starts at data so fetch wins the first contest
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_pend  <= 1'b0;
            ls_pend  <= 1'b0;
            last_win <= src_data;
            if_done  <= 1'b0;
            ls_done  <= 1'b0;
        end else begin
            if (if_req) begin
                if_pend <= 1'b1;
            end else if (if_grant) begin
                if_pend <= 1'b0;
            end
            if (ls_req) begin
                ls_pend <= 1'b1;
            end else if (ls_grant) begin
                ls_pend <= 1'b0;
            end
            // only a contested grant moves the priority
            if (contended) begin
                last_win <= winner;
            end
            if_done <= if_grant;
            ls_done <= ls_grant;
        end
    end

    // request payload and registered results
    always_ff @(posedge clk) begin
        if (if_req) begin
            if_va_q <= if_va;
        end
        if (ls_req) begin
            ls_va_q <= ls_va;
            ls_op_q <= ls_store ? acc_store : acc_load;
        end
        if (if_grant) begin
            if_pa <= xl_pa;
            if_ex <= xl_ex;
        end
        if (ls_grant) begin
            ls_pa <= xl_pa;
            ls_ex <= xl_ex;
        end
    end

endmodule

`default_nettype wire

//--- source/addr_translator.sv
`timescale 1ns/1ns
`default_nettype none

module addr_translator (
    input  wire xlate_pkg::vaddr_t     grant_va,
    input  wire xlate_pkg::access_t    grant_op,
    input  wire xlate_pkg::csr_word_t  csr_crmd,
    input  wire xlate_pkg::csr_word_t  csr_asid,
    input  wire xlate_pkg::csr_word_t  csr_dmw0,
    input  wire xlate_pkg::csr_word_t  csr_dmw1,
    // TLB search port
    output tlb_pkg::vppn_t             s_vppn,
    output logic                       s_va_bit12,
    output logic                       s_va_bit22,
    output tlb_pkg::asid_t             s_asid,
    input  wire                        s_found,
    input  wire tlb_pkg::ppn_t         s_ppn,
    input  wire tlb_pkg::ps_t          s_ps,
    input  wire tlb_pkg::plv_t         s_plv,
    input  wire                        s_d,
    input  wire                        s_v,
    // result
    output xlate_pkg::paddr_t          xl_pa,
    output xlate_pkg::xlate_ex_t       xl_ex
);
    import xlate_pkg::*;
    import tlb_pkg::*;

    plv_t   cur_plv;
    logic   direct;
    logic   dmw0_hit;
    logic   dmw1_hit;
    logic   tlb_path;
    paddr_t dmw0_pa;
    paddr_t dmw1_pa;
    paddr_t tlb_pa;

    assign cur_plv = csr_crmd[crmd_plv_lo +: 2];
    assign direct  = csr_crmd[crmd_da] & ~csr_crmd[crmd_pg];

    // window hit needs the enable bit of the current level
    assign dmw0_hit = csr_dmw0[cur_plv] && (csr_dmw0[dmw_vseg_hi -: 3] == grant_va[31:29]);
    assign dmw1_hit = csr_dmw1[cur_plv] && (csr_dmw1[dmw_vseg_hi -: 3] == grant_va[31:29]);
    assign dmw0_pa  = {csr_dmw0[dmw_pseg_hi -: 3], grant_va[28:0]};
    assign dmw1_pa  = {csr_dmw1[dmw_pseg_hi -: 3], grant_va[28:0]};

    assign tlb_path = ~direct & ~dmw0_hit & ~dmw1_hit;

    // search key
    assign s_vppn     = grant_va[31:13];
    assign s_va_bit12 = grant_va[12];
    assign s_va_bit22 = grant_va[22];
    assign s_asid     = csr_asid[9:0];

    assign tlb_pa = (s_ps == ps_4k) ? {s_ppn, grant_va[11:0]}
                                    : {s_ppn[19:10], grant_va[21:0]};

    // window 0 before window 1
    always_comb begin
        if (direct) begin
            xl_pa = grant_va;
        end else if (dmw0_hit) begin
            xl_pa = dmw0_pa;
        end else if (dmw1_hit) begin
            xl_pa = dmw1_pa;
        end else begin
            xl_pa = tlb_pa;
        end
    end

    // flags only come from the TLB path
    always_comb begin
        xl_ex = '0;
        if (tlb_path) begin
            if (!s_found) begin
                xl_ex[ex_tlbr] = 1'b1;
            end else begin
                xl_ex[ex_pif] = (grant_op == acc_fetch) & ~s_v;
                xl_ex[ex_pil] = (grant_op == acc_load) & ~s_v;
                xl_ex[ex_pis] = (grant_op == acc_store) & ~s_v;
                xl_ex[ex_ppi] = (cur_plv > s_plv);
                xl_ex[ex_pme] = (grant_op == acc_store) & ~s_d;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/tlb_array.sv
`timescale 1ns/1ns
`default_nettype none

module tlb_array (
    input  wire                     clk,
    input  wire                     rst_n,
    // write port
    input  wire                     tlb_we,
    input  wire tlb_pkg::tlb_idx_t  tlb_w_index,
    input  wire                     tlb_w_e,
    input  wire tlb_pkg::vppn_t     tlb_w_vppn,
    input  wire tlb_pkg::ps_t       tlb_w_ps,
    input  wire tlb_pkg::asid_t     tlb_w_asid,
    input  wire                     tlb_w_g,
    input  wire tlb_pkg::ppn_t      tlb_w_ppn0,
    input  wire tlb_pkg::plv_t      tlb_w_plv0,
    input  wire                     tlb_w_d0,
    input  wire                     tlb_w_v0,
    input  wire tlb_pkg::ppn_t      tlb_w_ppn1,
    input  wire tlb_pkg::plv_t      tlb_w_plv1,
    input  wire                     tlb_w_d1,
    input  wire                     tlb_w_v1,
    // search port
    input  wire tlb_pkg::vppn_t     s_vppn,
    input  wire                     s_va_bit12,
    input  wire                     s_va_bit22,
    input  wire tlb_pkg::asid_t     s_asid,
    output logic                    s_found,
    output tlb_pkg::ppn_t           s_ppn,
    output tlb_pkg::ps_t            s_ps,
    output tlb_pkg::plv_t           s_plv,
    output logic                    s_d,
    output logic                    s_v
);
    import tlb_pkg::*;

    // per entry tag fields
    logic [tlb_num-1:0] ent_e;
    logic [tlb_num-1:0] ent_g;
    vppn_t              ent_vppn [tlb_num];
    ps_t                ent_ps   [tlb_num];
    asid_t              ent_asid [tlb_num];

    // even and odd page of each pair
    ppn_t               ent_ppn0 [tlb_num];
    ppn_t               ent_ppn1 [tlb_num];
    plv_t               ent_plv0 [tlb_num];
    plv_t               ent_plv1 [tlb_num];
    logic [tlb_num-1:0] ent_d0;
    logic [tlb_num-1:0] ent_d1;
    logic [tlb_num-1:0] ent_v0;
    logic [tlb_num-1:0] ent_v1;

    wire  [tlb_num-1:0] ent_huge;
    wire  [tlb_num-1:0] match;
    tlb_idx_t           hit_idx;
    logic               odd;

    // reset invalidates every entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_e <= '0;
        end else if (tlb_we) begin
            ent_e[tlb_w_index] <= tlb_w_e;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_we) begin
            ent_vppn[tlb_w_index] <= tlb_w_vppn;
            ent_ps[tlb_w_index]   <= tlb_w_ps;
            ent_asid[tlb_w_index] <= tlb_w_asid;
            ent_g[tlb_w_index]    <= tlb_w_g;
            ent_ppn0[tlb_w_index] <= tlb_w_ppn0;
            ent_plv0[tlb_w_index] <= tlb_w_plv0;
            ent_d0[tlb_w_index]   <= tlb_w_d0;
            ent_v0[tlb_w_index]   <= tlb_w_v0;
            ent_ppn1[tlb_w_index] <= tlb_w_ppn1;
            ent_plv1[tlb_w_index] <= tlb_w_plv1;
            ent_d1[tlb_w_index]   <= tlb_w_d1;
            ent_v1[tlb_w_index]   <= tlb_w_v1;
        end
    end

    // parallel compare against every entry
    for (genvar i = 0; i < tlb_num; i++) begin : g_match
        assign ent_huge[i] = (ent_ps[i] == ps_4m);
        // a 4 MB pair covers 8 MB, so only va[31:23] is compared
        assign match[i] = ent_e[i]
            && (ent_huge[i] ? (ent_vppn[i][18:10] == s_vppn[18:10])
                            : (ent_vppn[i] == s_vppn))
            && (ent_g[i] || (ent_asid[i] == s_asid));
    end

    // lowest matching index wins
    always_comb begin
        hit_idx = '0;
        for (int i = tlb_num - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_idx = tlb_idx_t'(i);
            end
        end
    end

    // odd page select depends on the page size
    assign odd = ent_huge[hit_idx] ? s_va_bit22 : s_va_bit12;

    assign s_found = |match;
    assign s_ps    = ent_ps[hit_idx];
    assign s_ppn   = odd ? ent_ppn1[hit_idx] : ent_ppn0[hit_idx];
    assign s_plv   = odd ? ent_plv1[hit_idx] : ent_plv0[hit_idx];
    assign s_d     = odd ? ent_d1[hit_idx]   : ent_d0[hit_idx];
    assign s_v     = odd ? ent_v1[hit_idx]   : ent_v0[hit_idx];

endmodule

`default_nettype wire

//--- source/xlate_pkg.sv
`default_nettype none

package xlate_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [31:0] csr_word_t;

    // crmd fields
    // current privilege sits in bits 1:0
    localparam int crmd_plv_lo = 0;
    localparam int crmd_da     = 3;
    localparam int crmd_pg     = 4;

    // dmw segments are 3 bits wide and named by their top bit
    // plv enables live in bits 3:0, one per privilege level
    localparam int dmw_vseg_hi = 31;
    localparam int dmw_pseg_hi = 27;

    typedef enum logic [1:0] {
        acc_fetch = 2'd0,
        acc_load  = 2'd1,
        acc_store = 2'd2
    } access_t;

    // translation exception flags
    typedef logic [5:0] xlate_ex_t;

    localparam int ex_tlbr = 0;
    localparam int ex_pif  = 1;
    localparam int ex_pil  = 2;
    localparam int ex_pis  = 3;
    localparam int ex_ppi  = 4;
    localparam int ex_pme  = 5;

    // which requester owns the shared translator
    typedef enum logic {
        src_fetch = 1'b0,
        src_data  = 1'b1
    } req_src_t;

endpackage

`default_nettype wire

//--- source/tlb_pkg.sv
`default_nettype none

package tlb_pkg;

    // entry count of the fully associative TLB
    localparam int tlb_num = 16;

    typedef logic [$clog2(tlb_num)-1:0] tlb_idx_t;

    // virtual page pair number taken from va[31:13]
    typedef logic [18:0] vppn_t;

    typedef logic [9:0] asid_t;

    // physical page number giving pa[31:12] of a 4 KB page
    typedef logic [19:0] ppn_t;

    // page size as log2 of the byte count
    typedef logic [5:0] ps_t;

    // privilege level where 0 is the most privileged
    typedef logic [1:0] plv_t;

    // the two supported page sizes
    localparam ps_t ps_4k = 6'd12;
    localparam ps_t ps_4m = 6'd22;

endpackage

`default_nettype wire
